// File: verilog.f
rtl/posit_pkg.sv
rtl/posit_decoder.sv
rtl/fir_multiplier.sv
rtl/pack_fields.sv
rtl/posit_encoder.sv
rtl/round_posit.sv
rtl/fir_to_posit.sv
rtl/posit_mul_unit.sv
testbench/posit_mul_chk.sv
testbench/tb_posit_mul.sv

// File: Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert --top-module tb_posit_mul -f verilog.f -o sim_posit_mul
	@out="$$(./obj_dir/sim_posit_mul)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "sim passed"

clean:
	rm -rf obj_dir

// File: testbench/tb_posit_mul.sv
`timescale 1ns/100ps

module tb_posit_mul import posit_pkg::*; ();

    localparam int num_vec     = 17;
    localparam int cycle_limit = num_vec * 12 + 3;  // a dozen cycles per entry plus reset

    // ==============================
    // stimulus table, {a, b, expected}
    // ==============================
    localparam logic [3*posit_n-1:0] vec_table [num_vec] = '{
        24'h40_48_48,  // 1.0 * 1.5 is exact
        24'h50_50_60,  // 2.0 * 2.0 = 4.0
        24'h30_60_50,  // 0.5 * 4.0 = 2.0
        24'h64_64_74,  // 6 * 6 = 36, a tie that stays on the even pattern 32
        24'h63_68_76,  // 5.5 * 8 = 44, a tie that rounds up to even 48
        24'h64_65_75,  // 6 * 6.5 = 39, sticky bits push it up to 40
        24'h7f_60_7f,  // maxpos * 4 saturates
        24'h01_20_01,  // minpos * 0.25 saturates instead of reaching zero
        24'h81_60_81,  // -maxpos * 4
        24'hff_20_ff,  // -minpos * 0.25
        24'h00_48_00,  // zero times anything
        24'h80_40_80,  // NaR times one
        24'h80_00_80,  // NaR beats zero
        24'h48_50_58,  // 1.5 * 2.0 = 3.0
        24'hb8_50_a8,
        24'h48_b0_a8,
        24'hb8_b0_58   // both negative, so the sign cancels
    };

    logic               clk;
    logic               reset;
    logic               req;
    logic [posit_n-1:0] a;
    logic [posit_n-1:0] b;
    logic               ack;
    logic [posit_n-1:0] result;

    logic [31:0] seed;
    int          pass_count;
    int          fail_count;
    int          cycle_count = 0;

    posit_mul_unit u_posit_mul_unit (
        .clk    (clk),
        .reset  (reset),
        .req    (req),
        .a      (a),
        .b      (b),
        .ack    (ack),
        .result (result)
    );

    always #5 clk = ~clk;

    // the run is cut off if it drags on far beyond the table length
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            $display("timeout: the run went past %0d cycles without finishing", cycle_limit);
            $display("sim failed");
            $finish;
        end
    end

    function automatic logic [31:0] lcg_step(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // polls ack on falling edges until it reaches the wanted level
    task automatic wait_for_ack(input logic level, output logic seen);
        int n;
        seen = 1'b0;
        n    = 0;
        while (!seen && n < 6) begin
            @(negedge clk);
            if (ack === level)
                seen = 1'b1;
            n++;
        end
    endtask

    // ==============================
    // main sequence
    // ==============================
    initial begin
        logic [posit_n-1:0] op_a;
        logic [posit_n-1:0] op_b;
        logic [posit_n-1:0] expect_res;
        logic               seen;
        logic               entry_ok;
        int                 gap;
        int                 hold;

        clk        = 1'b0;
        reset      = 1'b1;
        req        = 1'b0;
        a          = '0;
        b          = '0;
        seed       = 32'h20af;
        pass_count = 0;
        fail_count = 0;

        repeat (3) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        if (ack !== 1'b0) begin
            $display("ERROR at %0t: ack is %b right after reset", $time, ack);
            fail_count++;
        end else begin
            $display("reset: ack low, ok");
            pass_count++;
        end

        for (int i = 0; i < num_vec; i++) begin
            {op_a, op_b, expect_res} = vec_table[i];
            entry_ok = 1'b1;
            seed = lcg_step(seed);
            gap  = (i % 4 == 3) ? 0 : int'(seed[17:16]);  // every fourth entry is back to back
            seed = lcg_step(seed);
            hold = int'(seed[20:16]) % 3;

            repeat (gap) @(negedge clk);
            a   = op_a;
            b   = op_b;
            req = 1'b1;

            wait_for_ack(1'b1, seen);
            if (!seen) begin
                $display("entry %0d: no ack arrived within 6 cycles of req", i);
                entry_ok = 1'b0;
            end else if (result !== expect_res) begin
                $display("ERROR at %0t: entry %0d, %h * %h gave %h, expected %h",
                         $time, i, op_a, op_b, result, expect_res);
                entry_ok = 1'b0;
            end

            // back-pressure: ack and result must not move while req stays up
            repeat (hold) begin
                @(negedge clk);
                if (ack !== 1'b1 || result !== expect_res) begin
                    $display("ERROR at %0t: entry %0d, ack %b result %h while req held",
                             $time, i, ack, result);
                    entry_ok = 1'b0;
                end
            end

            req = 1'b0;
            wait_for_ack(1'b0, seen);
            if (!seen) begin
                $display("entry %0d: ack stayed high after req was dropped", i);
                entry_ok = 1'b0;
            end

            if (entry_ok) begin
                $display("entry %0d: %h * %h = %h, ok", i, op_a, op_b, expect_res);
                pass_count++;
            end else begin
                $display("entry %0d: %h * %h, bad", i, op_a, op_b);
                fail_count++;
            end
        end

        $display("%0d checks passed, %0d checks failed", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

bind posit_mul_unit posit_mul_chk u_posit_mul_chk (
    .clk    (clk),
    .reset  (reset),
    .req    (req),
    .ack    (ack),
    .result (result),
    .state  (state)
);

// File: testbench/posit_mul_chk.sv
`timescale 1ns/100ps

module posit_mul_chk import posit_pkg::*; (
    input logic               clk,
    input logic               reset,
    input logic               req,
    input logic               ack,
    input logic [posit_n-1:0] result,
    input mul_state_t         state
);

    // ack may only come up while a request is pending
    ack_rise_needs_req: assert property (@(posedge clk) disable iff (reset)
        $rose(ack) |-> $past(req))
        else $error("ack rose while req was low");

    result_held: assert property (@(posedge clk) disable iff (reset)
        (ack && $past(ack)) |-> $stable(result))
        else $error("result changed while ack was high");

    // release of req in st_done drops ack on the next edge
    ack_falls_after_req: assert property (@(posedge clk) disable iff (reset)
        (state == st_done && !req) |=> !ack)
        else $error("ack still high one edge after req went low");

    ack_low_after_reset: assert property (@(posedge clk) reset |=> !ack)
        else $error("ack high after reset");

endmodule

// File: rtl/posit_mul_unit.sv
`timescale 1ns/100ps

module posit_mul_unit import posit_pkg::*; (
    input  logic               clk,
    input  logic               reset,
    input  logic               req,
    input  logic [posit_n-1:0] a,
    input  logic [posit_n-1:0] b,
    output logic               ack,
    output logic [posit_n-1:0] result
);

    mul_state_t state;

    logic [posit_n-1:0]        a_q;
    logic [posit_n-1:0]        b_q;

    logic                      sign_a;
    logic signed [te_size-1:0] total_exp_a;
    logic [mant_size-1:0]      frac_a;
    logic                      zero_a;
    logic                      nar_a;
    logic                      sign_b;
    logic signed [te_size-1:0] total_exp_b;
    logic [mant_size-1:0]      frac_b;
    logic                      zero_b;
    logic                      nar_b;

    logic [fir_total_size:0]   ops_in;
    logic [posit_n-1:0]        posit_prod;
    logic [posit_n-1:0]        result_next;

    // ==============================
    // datapath, settles within st_calc
    // ==============================
    posit_decoder u_dec_a (
        .posit     (a_q),
        .sign      (sign_a),
        .total_exp (total_exp_a),
        .frac      (frac_a),
        .is_zero   (zero_a),
        .is_nar    (nar_a)
    );

    posit_decoder u_dec_b (
        .posit     (b_q),
        .sign      (sign_b),
        .total_exp (total_exp_b),
        .frac      (frac_b),
        .is_zero   (zero_b),
        .is_nar    (nar_b)
    );

    fir_multiplier u_fir_multiplier (
        .sign_a      (sign_a),
        .total_exp_a (total_exp_a),
        .frac_a      (frac_a),
        .sign_b      (sign_b),
        .total_exp_b (total_exp_b),
        .frac_b      (frac_b),
        .ops_in      (ops_in)
    );

    fir_to_posit u_fir_to_posit (
        .ops_in (ops_in),
        .posit  (posit_prod)
    );

    // NaR wins over zero, so NaR times zero stays NaR
    always_comb begin
        if (nar_a || nar_b)
            result_next = posit_nar;
        else if (zero_a || zero_b)
            result_next = posit_zero;
        else
            result_next = posit_prod;
    end

    // ==============================
    // four-phase req/ack handler
    // ==============================
    always_ff @(posedge clk) begin
        if (reset) begin
            state  <= st_idle;
            result <= posit_zero;
        end else begin
            case (state)
                st_idle: if (req) state <= st_calc;
                st_calc: begin
                    result <= result_next;
                    state  <= st_done;
                end
                st_done: if (!req) state <= st_idle;  // hold ack until req drops
                default: state <= st_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == st_idle && req) begin
            a_q <= a;  // operands captured on acceptance
            b_q <= b;
        end
    end

    assign ack = (state == st_done);

endmodule

// File: rtl/fir_to_posit.sv
`timescale 1ns/100ps

module fir_to_posit import posit_pkg::*; (
    input  logic [fir_total_size:0] ops_in,  // fir followed by frac_truncated
    output logic [posit_n-1:0]      posit
);

    logic [fir_total_size-1:0] fir;
    logic                      frac_truncated;
    logic                      sign;
    logic signed [te_size-1:0] te;
    logic [frac_full_size-1:0] frac_full;

    logic signed [k_size-1:0]  k;
    logic [posit_es-1:0]       next_exp;
    logic [mant_size-1:0]      frac;
    logic                      round_bit;
    logic                      sticky_bit;
    logic                      k_is_oob;
    logic                      non_zero_frac_field_size;
    logic [posit_n-1:0]        posit_encoded;
    logic [posit_n-1:0]        posit_pre_sign;

    assign {fir, frac_truncated} = ops_in;
    assign {sign, te, frac_full} = fir;

    pack_fields u_pack_fields (
        .frac_full                (frac_full),
        .total_exp                (te),
        .frac_truncated           (frac_truncated),
        .k                        (k),
        .next_exp                 (next_exp),
        .frac                     (frac),
        .round_bit                (round_bit),
        .sticky_bit               (sticky_bit),
        .k_is_oob                 (k_is_oob),
        .non_zero_frac_field_size (non_zero_frac_field_size)
    );

    // the magnitude is encoded and rounded, the sign comes last
    posit_encoder u_posit_encoder (
        .sign  (1'b0),
        .k     (k),
        .exp   (next_exp),
        .frac  (frac),
        .posit (posit_encoded)
    );

    round_posit u_round_posit (
        .posit                    (posit_encoded),
        .round_bit                (round_bit),
        .sticky_bit               (sticky_bit),
        .k_is_oob                 (k_is_oob),
        .non_zero_frac_field_size (non_zero_frac_field_size),
        .posit_rounded            (posit_pre_sign)
    );

    assign posit = sign ? (~posit_pre_sign + 1'b1) : posit_pre_sign;

endmodule

// File: rtl/round_posit.sv
`timescale 1ns/100ps

module round_posit import posit_pkg::*; (
    input  logic [posit_n-1:0] posit,
    input  logic               round_bit,
    input  logic               sticky_bit,
    input  logic               k_is_oob,
    input  logic               non_zero_frac_field_size,
    output logic [posit_n-1:0] posit_rounded
);

    logic round_up;

    // ties go to an even last bit while fraction bits remain
    // with the exponent bit as the last place a set round bit always rounds up
    assign round_up = round_bit & (non_zero_frac_field_size ? (sticky_bit | posit[0]) : 1'b1);

    always_comb begin
        if (k_is_oob)
            posit_rounded = posit[posit_n-2] ? posit_maxpos : posit_minpos;  // clamped regime
        else if (round_up)
            posit_rounded = posit + 1'b1;
        else
            posit_rounded = posit;
    end

endmodule

// File: rtl/posit_encoder.sv
`timescale 1ns/100ps

module posit_encoder import posit_pkg::*; (
    input  logic                     sign,
    input  logic signed [k_size-1:0] k,
    input  logic [posit_es-1:0]      exp,
    input  logic [mant_size-1:0]     frac,
    output logic [posit_n-1:0]       posit
);

    logic                                     regime_bit;
    logic [k_size-1:0]                        run;
    logic [posit_es+mant_size:0]              tail;  // terminator, exp, frac
    logic [posit_es+mant_size+posit_n-1:0]    ext;
    logic [posit_es+mant_size+posit_n-1:0]    ext_sh;
    logic [posit_n-2:0]                       body;

    assign regime_bit = ~k[k_size-1];
    assign run        = regime_bit ? (k + 1'b1) : (~k + 1'b1);  // k+1 ones or -k zeros

    assign tail = {~regime_bit, exp, frac};
    assign ext  = {tail, {(posit_n-1){1'b0}}};

    // shift the tail down behind the run, filling with the regime bit
    assign ext_sh = (ext >> run) | (regime_bit ? ~({$bits(ext){1'b1}} >> run) : '0);

    assign body = ext_sh[$bits(ext)-1 -: posit_n-1];  // excess bits fall off the end

    assign posit = sign ? -{1'b0, body} : {1'b0, body};

endmodule

// File: rtl/pack_fields.sv
`timescale 1ns/100ps

module pack_fields import posit_pkg::*; (
    input  logic [frac_full_size-1:0]  frac_full,
    input  logic signed [te_size-1:0]  total_exp,
    input  logic                       frac_truncated,
    output logic signed [k_size-1:0]   k,
    output logic [posit_es-1:0]        next_exp,
    output logic [mant_size-1:0]       frac,
    output logic                       round_bit,
    output logic                       sticky_bit,
    output logic                       k_is_oob,
    output logic                       non_zero_frac_field_size
);

    logic signed [te_size-1:0]           k_raw;
    logic [posit_es+frac_full_size-1:0] stream;
    logic [posit_es+frac_full_size-1:0] stream_sh;
    int                                  regime_len;
    int                                  avail;

    // anything at or above maxpos, or below minpos, saturates
    assign k_is_oob = (total_exp >= (posit_n - 2) * (2 ** posit_es)) ||
                      (total_exp < -((posit_n - 2) * (2 ** posit_es)));

    assign frac = frac_full[frac_full_size-1 -: mant_size];

    always_comb begin
        k_raw = total_exp >>> posit_es;
        if (k_is_oob) begin
            k        = total_exp[te_size-1] ? k_size'(-(posit_n - 2)) : k_size'(posit_n - 2);
            next_exp = '0;
        end else begin
            k        = k_raw[k_size-1:0];
            next_exp = total_exp[posit_es-1:0];
        end

        // regime is the run plus its terminator, the rest of the body is left over
        regime_len = (k >= 0) ? (k + 2) : (1 - k);
        avail      = posit_n - 1 - regime_len;
        if (avail < 0)
            avail = 0;

        // first bit past the kept ones is the round bit
        stream     = {next_exp, frac_full};
        stream_sh  = stream << avail;
        round_bit  = stream_sh[posit_es+frac_full_size-1];
        sticky_bit = (|stream_sh[posit_es+frac_full_size-2:0]) | frac_truncated;

        non_zero_frac_field_size = (avail > posit_es);  // at least one fraction bit fits
    end

endmodule

// File: rtl/fir_multiplier.sv
`timescale 1ns/100ps

module fir_multiplier import posit_pkg::*; (
    input  logic                      sign_a,
    input  logic signed [te_size-1:0] total_exp_a,
    input  logic [mant_size-1:0]      frac_a,
    input  logic                      sign_b,
    input  logic signed [te_size-1:0] total_exp_b,
    input  logic [mant_size-1:0]      frac_b,
    output logic [fir_total_size:0]   ops_in
);

    logic [mant_size:0]         mant_a;
    logic [mant_size:0]         mant_b;
    logic [2*mant_size+1:0]     prod;  // two integer bits, value in [1, 4)
    logic                       norm;
    logic                       sign;
    logic signed [te_size-1:0]  te;
    logic [frac_full_size-1:0]  frac_full;
    logic                       frac_truncated;

    assign mant_a = {1'b1, frac_a};  // hidden one restored
    assign mant_b = {1'b1, frac_b};
    assign prod   = mant_a * mant_b;

    assign norm = prod[2*mant_size+1];  // product reached 2

    assign sign = sign_a ^ sign_b;
    assign te   = total_exp_a + total_exp_b + {{(te_size-1){1'b0}}, norm};

    // the leading one is dropped, the rest is left aligned
    assign frac_full = norm ? prod[2*mant_size:0] : {prod[2*mant_size-1:0], 1'b0};

    assign frac_truncated = 1'b0;  // the whole product fits in frac_full

    assign ops_in = {sign, te, frac_full, frac_truncated};

endmodule

// File: rtl/posit_decoder.sv
`timescale 1ns/100ps

module posit_decoder import posit_pkg::*; (
    input  logic [posit_n-1:0]        posit,
    output logic                      sign,
    output logic signed [te_size-1:0] total_exp,
    output logic [mant_size-1:0]      frac,
    output logic                      is_zero,
    output logic                      is_nar
);

    logic [posit_n-1:0]       mag;
    logic [posit_n-2:0]       body;  // everything below the sign
    logic [posit_n-2:0]       rest;  // exponent and fraction, left aligned
    logic [k_size-1:0]        run;
    logic                     hit_end;
    logic signed [k_size-1:0] k;
    logic [posit_es-1:0]      exp;

    assign is_zero = (posit == posit_zero);
    assign is_nar  = (posit == posit_nar);
    assign sign    = posit[posit_n-1];

    // negative posits are decoded from their two's complement
    assign mag  = sign ? (~posit + 1'b1) : posit;
    assign body = mag[posit_n-2:0];

    // length of the regime run, counted from the top
    always_comb begin
        run     = '0;
        hit_end = 1'b0;
        for (int i = posit_n - 2; i >= 0; i--) begin
            if (!hit_end && (body[i] == body[posit_n-2]))
                run = run + 1'b1;
            else
                hit_end = 1'b1;
        end
    end

    // a run of ones gives k = run - 1, a run of zeros gives k = -run
    assign k = body[posit_n-2] ? (run - 1'b1) : (~run + 1'b1);

    // drop the run and its terminating bit, zeros fill in from the right
    assign rest = body << (run + 1'b1);
    assign exp  = rest[posit_n-2 -: posit_es];
    assign frac = rest[posit_n-2-posit_es -: mant_size];

    // k * 2^es + exp, k sign extended
    assign total_exp = {{(te_size-k_size-posit_es){k[k_size-1]}}, k, exp};

endmodule

// File: rtl/posit_pkg.sv
package posit_pkg;

    // ==============================
    // posit<8,1> format
    // ==============================
    localparam int posit_n   = 8;
    localparam int posit_es  = 1;
    localparam int mant_size = posit_n - 3 - posit_es;  // widest fraction of one operand

    // ==============================
    // fir word fields
    // ==============================
    localparam int te_size        = 7;  // signed, holds the exponent of any product
    localparam int frac_full_size = 2 * mant_size + 1;  // product fraction without hidden one
    localparam int k_size         = 4;
    localparam int fir_total_size = 1 + te_size + frac_full_size;

    // special bit patterns
    localparam logic [posit_n-1:0] posit_zero   = '0;
    localparam logic [posit_n-1:0] posit_nar    = {1'b1, {(posit_n-1){1'b0}}};
    localparam logic [posit_n-1:0] posit_maxpos = 8'h7f;
    localparam logic [posit_n-1:0] posit_minpos = 8'h01;

    // req/ack handler states
    typedef enum logic [1:0] {
        st_idle,
        st_calc,
        st_done
    } mul_state_t;

endpackage
